//--- build.f
+incdir+source
source/core_pkg.sv
source/reg_file.sv
source/inst_decoder.sv
source/alu_unit.sv
source/load_store_unit.sv
source/core_ctrl.sv
source/core_top.sv
dv/core_properties.sv
dv/core_tb.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - include_dirs:
      - source
    files:
      - source/core_pkg.sv
      - source/reg_file.sv
      - source/inst_decoder.sv
      - source/alu_unit.sv
      - source/load_store_unit.sv
      - source/core_ctrl.sv
      - source/core_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/core_properties.sv
      - dv/core_tb.sv

//--- dv/core_tb.sv
`include "core_config.svh"

module core_tb;
    import core_pkg::*;

    localparam int         store_base  = 256;
    localparam int         preset_word = 16;
    localparam word_t      preset_a    = 32'h1234_5678;
    localparam word_t      preset_b    = 32'hcafe_f00d;
    localparam word_t      neg_val     = 32'hffff_fff0;
    localparam word_t      pos_val     = 32'd3;
    localparam logic [6:0] op_imm      = 7'b0010011;
    localparam logic [6:0] op_load     = 7'b0000011;

    logic                     clk;
    logic                     rstn;
    logic                     inst_req;
    logic [`CORE_IADDR_W-1:0] inst_addr;
    word_t                    inst_data;
    logic                     data_re;
    logic                     data_we;
    logic [`CORE_DADDR_W-1:0] data_addr;
    word_t                    data_wdata;
    word_t                    data_rdata;
    logic                     halted;

    word_t imem [1 << `CORE_IADDR_W];
    word_t dmem [1 << `CORE_DADDR_W];
    word_t exp_q [$];
    int    prog_len;
    int    store_idx;
    logic  inst_pend;
    word_t inst_word;
    logic  load_pend;
    word_t load_word;

    core_top i_core_top (
        .clk        (clk),
        .rstn       (rstn),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_data  (inst_data),
        .data_re    (data_re),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .halted     (halted)
    );

    always #5 clk = ~clk;

    function automatic word_t r_insn(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_insn(logic [6:0] opc, logic [2:0] f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t s_insn(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_insn(logic [2:0] f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t lui_insn(int rd, logic [19:0] imm);
        return {imm, rd[4:0], 7'b0110111};
    endfunction

    function automatic word_t jal_insn(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // sign extension of a 12-bit immediate
    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic emit(word_t insn);
        imem[prog_len] = insn;
        prog_len++;
    endtask

    // SW of rs into the next result slot, with the word it has to carry
    task automatic store_check(int rs, word_t value);
        emit(s_insn(rs, 10, 4 * exp_q.size()));
        exp_q.push_back(value);
    endtask

    // marker store that only a wrong branch or jump ever reaches
    task automatic skip_marker();
        emit(s_insn(7, 10, 4 * exp_q.size()));
    endtask

    task automatic stop_run(string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic load_program();
        int jal_at;
        emit(i_insn(op_imm, 3'b000, 1, 0, -16));
        emit(i_insn(op_imm, 3'b000, 2, 0, 3));
        emit(i_insn(op_imm, 3'b000, 10, 0, store_base));
        emit(i_insn(op_imm, 3'b000, 7, 0, 12'h555));
        emit(lui_insn(3, 20'h12345));
        store_check(3, 32'h12345 << 12);
        emit(r_insn(7'h00, 3'b000, 4, 1, 2));
        store_check(4, neg_val + pos_val);
        emit(r_insn(7'h20, 3'b000, 4, 2, 1));
        store_check(4, pos_val - neg_val);
        emit(r_insn(7'h00, 3'b001, 4, 1, 2));
        store_check(4, neg_val << pos_val[4:0]);
        emit(r_insn(7'h00, 3'b010, 4, 1, 2));
        store_check(4, {31'b0, $signed(neg_val) < $signed(pos_val)});
        emit(r_insn(7'h00, 3'b011, 4, 2, 1));
        store_check(4, {31'b0, pos_val < neg_val});
        emit(r_insn(7'h00, 3'b100, 4, 1, 7));
        store_check(4, neg_val ^ sext12(12'h555));
        emit(r_insn(7'h00, 3'b101, 4, 1, 2));
        store_check(4, neg_val >> pos_val[4:0]);
        emit(r_insn(7'h20, 3'b101, 4, 1, 2));
        store_check(4, $signed(neg_val) >>> pos_val[4:0]);
        emit(r_insn(7'h00, 3'b110, 4, 1, 7));
        store_check(4, neg_val | sext12(12'h555));
        emit(r_insn(7'h00, 3'b111, 4, 1, 7));
        store_check(4, neg_val & sext12(12'h555));
        emit(i_insn(op_imm, 3'b010, 4, 1, -1));
        store_check(4, {31'b0, $signed(neg_val) < $signed(sext12(12'hfff))});
        emit(i_insn(op_imm, 3'b100, 4, 1, 12'h0f0));
        store_check(4, neg_val ^ sext12(12'h0f0));
        emit(i_insn(op_imm, 3'b110, 4, 7, 12'hf00));
        store_check(4, sext12(12'h555) | sext12(12'hf00));
        emit(i_insn(op_imm, 3'b111, 4, 1, 12'h7f0));
        store_check(4, neg_val & sext12(12'h7f0));
        emit(i_insn(op_imm, 3'b001, 4, 2, 5));
        store_check(4, pos_val << 5);
        emit(i_insn(op_imm, 3'b101, 4, 1, 4));
        store_check(4, neg_val >> 4);
        emit(i_insn(op_load, 3'b010, 5, 0, 4 * preset_word));
        store_check(5, preset_a);
        emit(i_insn(op_load, 3'b010, 5, 0, 4 * preset_word + 4));
        store_check(5, preset_b);
        // first result word read back
        emit(i_insn(op_load, 3'b010, 6, 10, 0));
        store_check(6, 32'h12345 << 12);
        emit(i_insn(op_imm, 3'b000, 0, 0, 123));
        store_check(0, 32'd0);
        // a wrongly taken branch lands on the next marker
        emit(b_insn(3'b000, 2, 2, 8));
        skip_marker();
        emit(b_insn(3'b000, 1, 2, 8));
        emit(b_insn(3'b001, 1, 2, 8));
        skip_marker();
        emit(b_insn(3'b001, 2, 2, 8));
        emit(b_insn(3'b100, 1, 2, 8));
        skip_marker();
        emit(b_insn(3'b100, 2, 1, 8));
        emit(b_insn(3'b101, 2, 1, 8));
        skip_marker();
        emit(b_insn(3'b101, 1, 2, 8));
        store_check(2, pos_val);
        jal_at = prog_len;
        emit(jal_insn(8, 8));
        skip_marker();
        store_check(8, 4 * jal_at + 4);
        // unsupported opcode
        emit(32'hffff_ffff);
    endtask

    // instruction memory, word valid the cycle after the request
    always @(negedge clk) begin
        inst_pend <= inst_req;
        if (inst_req) begin
            inst_word <= imem[inst_addr];
        end
        if (inst_pend) begin
            inst_data <= inst_word;
        end
    end

    always @(negedge clk) begin
        load_pend <= data_re;
        if (data_re) begin
            load_word <= dmem[data_addr];
        end
        if (load_pend) begin
            data_rdata <= load_word;
        end
        if (data_we) begin
            store_ok: assert (store_idx < exp_q.size()
                              && data_addr == (store_base / 4) + store_idx
                              && data_wdata == exp_q[store_idx])
            else begin
                stop_run($sformatf("FAILED at %0t: store %0d wrote %h to word %0d",
                                   $time, store_idx, data_wdata, data_addr));
            end
            dmem[data_addr] <= data_wdata;
            store_idx       <= store_idx + 1;
        end
    end

    always @(negedge clk) begin
        props_ok: assert (i_core_top.i_core_properties.error_count == 0)
        else begin
            stop_run("a protocol assertion on the core ports failed");
        end
    end

    task automatic wait_store(int k);
        int cycles;
        cycles = 0;
        while (store_idx <= k && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (store_idx <= k) begin
            stop_run($sformatf("timeout: store %0d never came", k));
        end
    endtask

    task automatic expect_halt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            stop_run("timeout: the core did not halt on the illegal opcode");
        end
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        inst_data  = '0;
        data_rdata = '0;
        inst_pend  = 1'b0;
        load_pend  = 1'b0;
        store_idx  = 0;
        prog_len   = 0;
        // illegal opcode everywhere outside the program
        for (int i = 0; i < (1 << `CORE_IADDR_W); i++) begin
            imem[i] = word_t'(i) << 7;
        end
        for (int i = 0; i < (1 << `CORE_DADDR_W); i++) begin
            dmem[i] = 32'h5a5a_0000 ^ word_t'(i);
        end
        dmem[preset_word]     = preset_a;
        dmem[preset_word + 1] = preset_b;
        load_program();
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        for (int k = 0; k < exp_q.size(); k++) begin
            wait_store(k);
        end
        expect_halt();
        repeat (20) @(negedge clk);
        if (store_idx == exp_q.size() && halted) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_run("stray store or halt dropped after the program ended");
        end
    end

endmodule

//--- dv/core_properties.sv
module core_properties (
    input logic clk,
    input logic rstn,
    input logic inst_req,
    input logic data_re,
    input logic data_we,
    input logic halted
);

    // read by the testbench
    int error_count = 0;

    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rstn) !(data_re && data_we)
    ) else begin
        error_count++;
        $error("data_re and data_we high in the same cycle");
    end

    quiet_in_halt: assert property (
        @(posedge clk) disable iff (!rstn) halted |-> !(inst_req || data_re || data_we)
    ) else begin
        error_count++;
        $error("memory strobe while halted");
    end

    // only reset leaves halt
    halt_sticky: assert property (
        @(posedge clk) disable iff (!rstn) halted |=> halted
    ) else begin
        error_count++;
        $error("halted fell without reset");
    end

    reset_quiet: assert property (
        @(posedge clk) !rstn |=> !(inst_req || data_re || data_we)
    ) else begin
        error_count++;
        $error("memory strobe during reset");
    end

endmodule

bind core_top core_properties i_core_properties (
    .clk      (clk),
    .rstn     (rstn),
    .inst_req (inst_req),
    .data_re  (data_re),
    .data_we  (data_we),
    .halted   (halted)
);

//--- source/core_top.sv
`include "core_config.svh"

module core_top (
    input  logic                      clk,
    input  logic                      rstn,
    output logic                      inst_req,
    output logic [`CORE_IADDR_W-1:0]  inst_addr,
    input  core_pkg::word_t           inst_data,
    output logic                      data_re,
    output logic                      data_we,
    output logic [`CORE_DADDR_W-1:0]  data_addr,
    output core_pkg::word_t           data_wdata,
    input  core_pkg::word_t           data_rdata,
    output logic                      halted
);
    import core_pkg::*;

    word_t        insn;
    word_t        pc;
    reg_addr_t    rs1_addr;
    reg_addr_t    rs2_addr;
    word_t        rs1_data;
    word_t        rs2_data;
    decoded_t     dec;
    decoded_t     op;
    logic         alu_start;
    logic         alu_done;
    exec_result_t alu_res;
    logic         lsu_start;
    logic         lsu_done;
    exec_result_t lsu_res;
    logic         rd_we;
    reg_addr_t    rd_addr;
    word_t        rd_data;

    core_ctrl i_core_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .inst_data (inst_data),
        .inst_req  (inst_req),
        .inst_addr (inst_addr),
        .dec       (dec),
        .insn      (insn),
        .pc        (pc),
        .alu_start (alu_start),
        .alu_res   (alu_res),
        .alu_done  (alu_done),
        .lsu_start (lsu_start),
        .lsu_res   (lsu_res),
        .lsu_done  (lsu_done),
        .op        (op),
        .rd_we     (rd_we),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .halted    (halted)
    );

    inst_decoder i_inst_decoder (
        .insn     (insn),
        .pc       (pc),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rd_we),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    alu_unit i_alu_unit (
        .clk   (clk),
        .rstn  (rstn),
        .start (alu_start),
        .op    (op),
        .res   (alu_res),
        .done  (alu_done)
    );

    load_store_unit i_load_store_unit (
        .clk        (clk),
        .rstn       (rstn),
        .start      (lsu_start),
        .op         (op),
        .data_re    (data_re),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .res        (lsu_res),
        .done       (lsu_done)
    );

endmodule

//--- source/core_ctrl.sv
`include "core_config.svh"

module core_ctrl (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_pkg::word_t           inst_data,
    output logic                      inst_req,
    output logic [`CORE_IADDR_W-1:0]  inst_addr,
    input  core_pkg::decoded_t        dec,
    output core_pkg::word_t           insn,
    output core_pkg::word_t           pc,
    output logic                      alu_start,
    input  core_pkg::exec_result_t    alu_res,
    input  logic                      alu_done,
    output logic                      lsu_start,
    input  core_pkg::exec_result_t    lsu_res,
    input  logic                      lsu_done,
    output core_pkg::decoded_t        op,
    output logic                      rd_we,
    output core_pkg::reg_addr_t       rd_addr,
    output core_pkg::word_t           rd_data,
    output logic                      halted
);
    import core_pkg::*;

    ctrl_state_e  state;
    ctrl_state_e  state_d;
    word_t        wb_value;
    word_t        next_pc;
    logic         taken;
    logic         uses_lsu;
    logic         unit_done;
    exec_result_t unit_res;

    assign uses_lsu  = op.unit inside {unit_load, unit_store};
    assign unit_done = uses_lsu ? lsu_done : alu_done;
    assign unit_res  = uses_lsu ? lsu_res : alu_res;

    assign alu_start = (state == st_execute) && (op.unit inside {unit_alu, unit_branch});
    assign lsu_start = (state == st_execute) && uses_lsu;

    always_comb begin
        state_d = state;
        case (state)
            // the request strobe is issued on entry, so a cold start waits one cycle
            st_fetch: begin
                if (inst_req) begin
                    state_d = st_fetch_wait;
                end
            end
            st_fetch_wait: state_d = st_decode;
            st_decode:     state_d = st_execute;
            st_execute: begin
                case (op.unit)
                    unit_alu, unit_branch, unit_load, unit_store: state_d = st_execute_wait;
                    unit_jal: state_d = st_write;
                    default:  state_d = st_halt;
                endcase
            end
            st_execute_wait: begin
                if (unit_done) begin
                    state_d = st_write;
                end
            end
            st_write: state_d = st_fetch;
            default:  state_d = st_halt;
        endcase
    end

    assign next_pc = ((op.unit == unit_jal) || (op.unit == unit_branch && taken)) ?
                     op.target : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= st_fetch;
            pc       <= `CORE_RESET_PC;
            inst_req <= 1'b0;
        end else begin
            state    <= state_d;
            inst_req <= (state_d == st_fetch);
            if (state == st_write) begin
                pc <= {next_pc[`CORE_XLEN-1:2], 2'b00};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch_wait) begin
            insn <= inst_data;
        end
        if (state == st_decode) begin
            op <= dec;
        end
        // jal link value
        if (state == st_execute) begin
            wb_value <= pc + 32'd4;
        end
        if (state == st_execute_wait && unit_done) begin
            wb_value <= unit_res.value;
            taken    <= unit_res.taken;
        end
    end

    assign inst_addr = pc[`CORE_IADDR_W+1:2];
    assign rd_we     = (state == st_write) && op.rd_write;
    assign rd_addr   = op.rd;
    assign rd_data   = wb_value;
    assign halted    = (state == st_halt);

endmodule

//--- source/load_store_unit.sv
`include "core_config.svh"

module load_store_unit (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    input  core_pkg::decoded_t        op,
    output logic                      data_re,
    output logic                      data_we,
    output logic [`CORE_DADDR_W-1:0]  data_addr,
    output core_pkg::word_t           data_wdata,
    input  core_pkg::word_t           data_rdata,
    output core_pkg::exec_result_t    res,
    output logic                      done
);
    import core_pkg::*;

    word_t byte_addr;
    logic  load_pend;

    assign byte_addr = op.operand_a + op.operand_b;

    // strobes go out the cycle after start
    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_re   <= 1'b0;
            data_we   <= 1'b0;
            load_pend <= 1'b0;
        end else begin
            data_re   <= start && (op.unit == unit_load);
            data_we   <= start && (op.unit == unit_store);
            load_pend <= data_re;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            data_addr  <= byte_addr[`CORE_DADDR_W+1:2];
            data_wdata <= op.store_data;
        end
    end

    // read data is valid while load_pend is high, the controller takes it then
    assign done = data_we | load_pend;
    assign res  = '{value: data_rdata, taken: 1'b0};

endmodule

//--- source/alu_unit.sv
`include "core_config.svh"

module alu_unit (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start,
    input  core_pkg::decoded_t     op,
    output core_pkg::exec_result_t res,
    output logic                   done
);
    import core_pkg::*;

    word_t      a;
    word_t      b;
    word_t      value;
    logic [4:0] shamt;
    logic       cond;

    assign a     = op.operand_a;
    assign b     = op.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (op.alu_op)
            alu_add:    value = a + b;
            alu_sub:    value = a - b;
            alu_sll:    value = a << shamt;
            alu_slt:    value = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   value = {{(`CORE_XLEN-1){1'b0}}, a < b};
            alu_xor:    value = a ^ b;
            alu_srl:    value = a >> shamt;
            alu_sra:    value = $signed(a) >>> shamt;
            alu_or:     value = a | b;
            alu_and:    value = a & b;
            alu_pass_b: value = b;
            default:    value = '0;
        endcase
    end

    // branches compare rs1 against rs2, which rides in store_data
    always_comb begin
        case (op.br_cond)
            br_eq:   cond = (a == op.store_data);
            br_ne:   cond = (a != op.store_data);
            br_lt:   cond = ($signed(a) < $signed(op.store_data));
            default: cond = ($signed(a) >= $signed(op.store_data));
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res.value <= value;
            res.taken <= (op.unit == unit_branch) && cond;
        end
    end

endmodule

//--- source/inst_decoder.sv
module inst_decoder (
    input  core_pkg::word_t     insn,
    input  core_pkg::word_t     pc,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::word_t     rs1_data,
    input  core_pkg::word_t     rs2_data,
    output core_pkg::decoded_t  dec
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode   = insn[6:0];
    assign funct3   = insn[14:12];
    assign funct7   = insn[31:25];
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        dec.unit       = unit_illegal;
        dec.alu_op     = alu_add;
        dec.br_cond    = br_eq;
        dec.rd         = insn[11:7];
        dec.operand_a  = rs1_data;
        dec.operand_b  = rs2_data;
        dec.store_data = rs2_data;
        dec.target     = pc + imm_b;

        case (opcode)
            7'b0110011: begin
                dec.unit = unit_alu;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = alu_add;
                    {7'b0100000, 3'b000}: dec.alu_op = alu_sub;
                    {7'b0000000, 3'b001}: dec.alu_op = alu_sll;
                    {7'b0000000, 3'b010}: dec.alu_op = alu_slt;
                    {7'b0000000, 3'b011}: dec.alu_op = alu_sltu;
                    {7'b0000000, 3'b100}: dec.alu_op = alu_xor;
                    {7'b0000000, 3'b101}: dec.alu_op = alu_srl;
                    {7'b0100000, 3'b101}: dec.alu_op = alu_sra;
                    {7'b0000000, 3'b110}: dec.alu_op = alu_or;
                    {7'b0000000, 3'b111}: dec.alu_op = alu_and;
                    default:              dec.unit   = unit_illegal;
                endcase
            end
            7'b0010011: begin
                dec.unit      = unit_alu;
                dec.operand_b = imm_i;
                case (funct3)
                    3'b000: dec.alu_op = alu_add;
                    3'b010: dec.alu_op = alu_slt;
                    3'b100: dec.alu_op = alu_xor;
                    3'b110: dec.alu_op = alu_or;
                    3'b111: dec.alu_op = alu_and;
                    3'b001: begin
                        dec.alu_op = alu_sll;
                        if (funct7 != 7'b0000000) begin
                            dec.unit = unit_illegal;
                        end
                    end
                    3'b101: begin
                        dec.alu_op = alu_srl;
                        if (funct7 != 7'b0000000) begin
                            dec.unit = unit_illegal;
                        end
                    end
                    // no SLTIU here
                    default: dec.unit = unit_illegal;
                endcase
            end
            7'b0110111: begin
                dec.unit      = unit_alu;
                dec.alu_op    = alu_pass_b;
                dec.operand_b = imm_u;
            end
            7'b0000011: begin
                dec.unit      = (funct3 == 3'b010) ? unit_load : unit_illegal;
                dec.operand_b = imm_i;
            end
            7'b0100011: begin
                dec.unit      = (funct3 == 3'b010) ? unit_store : unit_illegal;
                dec.operand_b = imm_s;
            end
            7'b1100011: begin
                dec.unit   = unit_branch;
                dec.alu_op = alu_sub;
                case (funct3)
                    3'b000:  dec.br_cond = br_eq;
                    3'b001:  dec.br_cond = br_ne;
                    3'b100:  dec.br_cond = br_lt;
                    3'b101:  dec.br_cond = br_ge;
                    default: dec.unit    = unit_illegal;
                endcase
            end
            7'b1101111: begin
                dec.unit   = unit_jal;
                dec.target = pc + imm_j;
            end
            default: dec.unit = unit_illegal;
        endcase

        dec.rd_write = dec.unit inside {unit_alu, unit_load, unit_jal};
    end

endmodule

//--- source/reg_file.sv
`include "core_config.svh"

module reg_file (
    input  logic                clk,
    input  logic                rstn,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                we,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::word_t     rd_data
);
    import core_pkg::*;

    word_t regs [`CORE_NREGS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is never written and keeps its reset zero
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- source/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [$clog2(`CORE_NREGS)-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        br_eq,
        br_ne,
        br_lt,
        br_ge
    } br_cond_e;

    typedef enum logic [2:0] {
        unit_alu,
        unit_load,
        unit_store,
        unit_branch,
        unit_jal,
        unit_illegal
    } unit_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write,
        st_halt
    } ctrl_state_e;

    // one decoded instruction, latched by the controller in decode
    typedef struct packed {
        unit_e     unit;
        alu_op_e   alu_op;
        br_cond_e  br_cond;
        reg_addr_t rd;
        logic      rd_write;
        word_t     operand_a;
        word_t     operand_b;
        word_t     store_data;
        word_t     target;
    } decoded_t;

    typedef struct packed {
        word_t value;
        logic  taken;
    } exec_result_t;

endpackage

//--- source/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath word width
`define CORE_XLEN 32

// architectural registers, x0 included
`define CORE_NREGS 32

// word address widths of the two memories
`define CORE_IADDR_W 10
`define CORE_DADDR_W 10

// byte address of the first fetch
`define CORE_RESET_PC 32'h0000_0000

`endif
